// File: include/switch_settings.svh
`ifndef SWITCH_SETTINGS_SVH
`define SWITCH_SETTINGS_SVH

// switch geometry.
`define SW_PORTS 4
`define SW_PRIORS 4
`define SW_SLOTS 4
`define SW_WORDS 8

// data path width.
`define SW_DATA_W 16

// header word fields.
`define SW_DEST_LSB 0
`define SW_PRIOR_LSB 4

`endif

// File: src/switch_pkg.sv
`default_nettype none
`include "switch_settings.svh"

package switch_pkg;

    typedef logic [`SW_PORTS-1:0] port_vec_t;               // one bit per port or bank.
    typedef logic [$clog2(`SW_PORTS)-1:0] port_id_t;
    typedef logic [$clog2(`SW_PRIORS)-1:0] prior_t;
    typedef logic [$clog2(`SW_SLOTS)-1:0] slot_idx_t;
    typedef logic [$clog2(`SW_SLOTS+1)-1:0] slot_cnt_t;     // free slots in one bank.
    typedef logic [$clog2(`SW_WORDS)-1:0] word_idx_t;
    typedef logic [$clog2(`SW_WORDS)-1:0] len_t;            // words minus one.
    typedef logic [`SW_DATA_W-1:0] data_t;

    // global slot address, bank in the upper bits.
    typedef struct packed {
        port_id_t  bank;
        slot_idx_t slot;
    } slot_addr_t;

    typedef enum logic [1:0] {WR_IDLE, WR_BODY, WR_JOIN} wr_state_t;
    typedef enum logic [1:0] {RD_IDLE, RD_WAIT_BANK, RD_STREAM} rd_state_t;

    // first requester at or after start, wrapping.
    function automatic port_id_t rr_pick(input port_vec_t req, input port_id_t start);
        port_id_t pick;
        pick = start;
        for (int i = `SW_PORTS - 1; i >= 0; i--) begin
            if (req[port_id_t'(start + i)]) begin
                pick = port_id_t'(start + i);   // lowest offset wins.
            end
        end
        return pick;
    endfunction

endpackage

`default_nettype wire

// File: src/port_wr_frontend.sv
`timescale 1ns/10ps
`default_nettype none
`include "switch_settings.svh"

module port_wr_frontend
    import switch_pkg::*;
#(
    parameter port_id_t BANK = '0
) (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       wr_sop,
    input  logic       wr_eop,
    input  logic       wr_vld,
    input  data_t      wr_data,
    input  logic       has_free,
    input  slot_idx_t  free_slot,
    input  logic       join_gnt,
    output logic       pause,
    output logic       mem_we,
    output slot_idx_t  mem_slot,
    output word_idx_t  mem_word,
    output data_t      mem_data,
    output logic       len_we,
    output len_t       len,
    output logic       join_req,
    output port_id_t   join_dest,
    output prior_t     join_prior,
    output slot_addr_t join_addr
);

    wr_state_t state;
    slot_idx_t slot_q;
    word_idx_t cnt;                                 // next word index in the body.
    logic      take_sop;

    assign take_sop = (state == WR_IDLE) && wr_vld && wr_sop;

    // word 0 goes straight into the slot the bank offers.
    assign mem_we   = take_sop || (state == WR_BODY && wr_vld);
    assign mem_slot = (state == WR_IDLE) ? free_slot : slot_q;
    assign mem_word = (state == WR_IDLE) ? '0 : cnt;
    assign mem_data = wr_data;
    assign len_we   = mem_we && wr_eop;
    assign len      = len_t'(mem_word);             // index of the last word.

    assign pause     = (state == WR_JOIN) || (state == WR_IDLE && !has_free);
    assign join_req  = (state == WR_JOIN);
    assign join_addr = '{bank: BANK, slot: slot_q};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= WR_IDLE;
        end else begin
            case (state)
                WR_IDLE: if (take_sop) state <= wr_eop ? WR_JOIN : WR_BODY;
                WR_BODY: if (wr_vld && wr_eop) state <= WR_JOIN;
                WR_JOIN: if (join_gnt) state <= WR_IDLE;  // held until the arbiter takes it.
                default: state <= WR_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_sop) begin
            slot_q     <= free_slot;
            join_dest  <= wr_data[`SW_DEST_LSB +: $bits(port_id_t)];
            join_prior <= wr_data[`SW_PRIOR_LSB +: $bits(prior_t)];
            cnt        <= word_idx_t'(1);
        end else if (mem_we) begin
            cnt <= cnt + 1'b1;
        end
    end

    a_no_sop_paused: assert property (@(posedge clk) disable iff (!rst_n)
        pause |-> !(wr_vld && wr_sop));

    // the last word a slot can hold must close the packet.
    a_max_words: assert property (@(posedge clk) disable iff (!rst_n)
        (state == WR_BODY && wr_vld && cnt == word_idx_t'(`SW_WORDS - 1)) |-> wr_eop);

endmodule

`default_nettype wire

// File: src/sram_bank.sv
`timescale 1ns/10ps
`default_nettype none
`include "switch_settings.svh"

module sram_bank
    import switch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      mem_we,
    input  slot_idx_t mem_slot,
    input  word_idx_t mem_word,
    input  data_t     mem_data,
    input  logic      len_we,
    input  len_t      len,
    input  port_vec_t rd_req,
    input  slot_idx_t rd_slot_in [`SW_PORTS],
    output logic      has_free,
    output slot_idx_t free_slot,
    output slot_cnt_t free_cnt,
    output port_vec_t rd_gnt,
    output logic      bank_vld,
    output data_t     bank_data,
    output logic      bank_last
);

    data_t                mem [`SW_SLOTS * `SW_WORDS];
    len_t                 len_tab [`SW_SLOTS];
    logic [`SW_SLOTS-1:0] free_map;                 // set bit means slot is free.
    logic                 busy;
    slot_idx_t            rd_slot_q;
    word_idx_t            rd_word_q;
    port_id_t             rr_ptr;
    port_id_t             win;

    always_ff @(posedge clk) begin
        if (mem_we) mem[{mem_slot, mem_word}] <= mem_data;
        if (len_we) len_tab[mem_slot] <= len;
    end

    // lowest free slot is offered next.
    always_comb begin
        free_slot = '0;
        free_cnt  = '0;
        for (int s = `SW_SLOTS - 1; s >= 0; s--) begin
            if (free_map[s]) begin
                free_slot = slot_idx_t'(s);
                free_cnt  = free_cnt + 1'b1;
            end
        end
    end

    assign has_free = |free_map;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            free_map <= '1;
        end else begin
            if (mem_we && mem_word == '0) free_map[mem_slot] <= 1'b0;   // reserve on word 0.
            if (bank_last) free_map[rd_slot_q] <= 1'b1;
        end
    end

    // one out port at a time, granted only while idle.
    assign win    = rr_pick(rd_req, rr_ptr);
    assign rd_gnt = (!busy && |rd_req) ? (port_vec_t'(1) << win) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            rr_ptr <= '0;
        end else if (!busy) begin
            if (|rd_req) begin
                busy   <= 1'b1;
                rr_ptr <= win + 1'b1;
            end
        end else if (bank_last) begin
            busy <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!busy && |rd_req) begin
            rd_slot_q <= rd_slot_in[win];
            rd_word_q <= '0;
        end else if (busy) begin
            rd_word_q <= rd_word_q + 1'b1;
        end
    end

    assign bank_vld  = busy;                        // first word the cycle after grant.
    assign bank_data = mem[{rd_slot_q, rd_word_q}];
    assign bank_last = busy && (rd_word_q == len_tab[rd_slot_q]);

    a_read_not_free: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !free_map[rd_slot_q]);

endmodule

`default_nettype wire

// File: src/join_arbiter.sv
`timescale 1ns/10ps
`default_nettype none
`include "switch_settings.svh"

module join_arbiter
    import switch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  port_vec_t  join_req,
    input  port_id_t   join_dest [`SW_PORTS],
    input  prior_t     join_prior [`SW_PORTS],
    input  slot_addr_t join_addr [`SW_PORTS],
    output port_vec_t  join_gnt,
    output port_vec_t  enq,
    output prior_t     enq_prior,
    output slot_addr_t enq_addr
);

    port_id_t rr_ptr;                               // first port tried this cycle.
    port_id_t win;

    assign win = rr_pick(join_req, rr_ptr);

    // grant and enqueue land on the same edge.
    assign join_gnt  = (|join_req) ? (port_vec_t'(1) << win) : '0;
    assign enq       = (|join_req) ? (port_vec_t'(1) << join_dest[win]) : '0;
    assign enq_prior = join_prior[win];
    assign enq_addr  = join_addr[win];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rr_ptr <= '0;
        end else if (|join_req) begin
            rr_ptr <= win + 1'b1;                   // start after the last winner.
        end
    end

endmodule

`default_nettype wire

// File: src/port_queue_mgr.sv
`timescale 1ns/10ps
`default_nettype none
`include "switch_settings.svh"

module port_queue_mgr
    import switch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       enq,
    input  prior_t     enq_prior,
    input  slot_addr_t enq_addr,
    input  logic       pop,
    output slot_addr_t head_addr,
    output logic       has_pkt
);

    // a queue never holds more entries than there are slots.
    localparam int DEPTH = `SW_PORTS * `SW_SLOTS;
    localparam int PW    = $clog2(DEPTH);

    slot_addr_t            fifo_mem [`SW_PRIORS][DEPTH];
    logic [PW:0]           wr_ptr [`SW_PRIORS];     // extra bit tells full from empty.
    logic [PW:0]           rd_ptr [`SW_PRIORS];
    logic [`SW_PRIORS-1:0] empty;
    logic [`SW_PRIORS-1:0] full;
    prior_t                head_prior;

    for (genvar p = 0; p < `SW_PRIORS; p++) begin : g_flags
        assign empty[p] = (wr_ptr[p] == rd_ptr[p]);
        assign full[p]  = ((wr_ptr[p] ^ rd_ptr[p]) == {1'b1, {PW{1'b0}}});
    end

    // strict priority, 0 first.
    always_comb begin
        head_prior = '0;
        for (int p = `SW_PRIORS - 1; p >= 0; p--) begin
            if (!empty[p]) head_prior = prior_t'(p);
        end
    end

    assign has_pkt   = |(~empty);
    assign head_addr = fifo_mem[head_prior][rd_ptr[head_prior][PW-1:0]];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < `SW_PRIORS; p++) begin
                wr_ptr[p] <= '0;
                rd_ptr[p] <= '0;
            end
        end else begin
            if (enq) wr_ptr[enq_prior] <= wr_ptr[enq_prior] + 1'b1;
            if (pop) rd_ptr[head_prior] <= rd_ptr[head_prior] + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (enq) fifo_mem[enq_prior][wr_ptr[enq_prior][PW-1:0]] <= enq_addr;
    end

    a_pop_nonempty: assert property (@(posedge clk) disable iff (!rst_n)
        pop |-> has_pkt);

    a_enq_not_full: assert property (@(posedge clk) disable iff (!rst_n)
        enq |-> !full[enq_prior]);

endmodule

`default_nettype wire

// File: src/port_rd_frontend.sv
`timescale 1ns/10ps
`default_nettype none
`include "switch_settings.svh"

module port_rd_frontend
    import switch_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ready,
    input  logic       has_pkt,
    input  slot_addr_t head_addr,
    input  logic       gnt,
    input  logic       bank_vld [`SW_PORTS],
    input  data_t      bank_data [`SW_PORTS],
    input  logic       bank_last [`SW_PORTS],
    output logic       pop,
    output port_vec_t  bank_req,
    output slot_idx_t  rd_slot,
    output logic       rd_sop,
    output logic       rd_eop,
    output logic       rd_vld,
    output data_t      rd_data
);

    rd_state_t state;
    port_id_t  cur_bank;                            // bank streaming to this port.
    logic      first_q;

    // request tracks the queue head until granted, so a later
    // higher priority packet still goes first.
    assign rd_slot  = head_addr.slot;
    assign bank_req = (state == RD_WAIT_BANK) ? (port_vec_t'(1) << head_addr.bank) : '0;
    assign pop      = (state == RD_WAIT_BANK) && gnt;

    assign rd_vld  = (state == RD_STREAM) && bank_vld[cur_bank];
    assign rd_sop  = rd_vld && first_q;
    assign rd_eop  = rd_vld && bank_last[cur_bank];
    assign rd_data = bank_data[cur_bank];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= RD_IDLE;
            first_q <= 1'b0;
        end else begin
            case (state)
                RD_IDLE: if (ready && has_pkt) state <= RD_WAIT_BANK;  // ready sampled here only.
                RD_WAIT_BANK: begin
                    if (gnt) begin
                        state   <= RD_STREAM;
                        first_q <= 1'b1;
                    end
                end
                RD_STREAM: begin
                    if (rd_vld) first_q <= 1'b0;
                    if (rd_eop) state <= RD_IDLE;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) cur_bank <= head_addr.bank;
    end

    // the bank never gaps a packet once it has started.
    a_contiguous: assert property (@(posedge clk) disable iff (!rst_n)
        state == RD_STREAM |-> bank_vld[cur_bank]);

endmodule

`default_nettype wire

// File: src/hydra_switch.sv
`timescale 1ns/10ps
`default_nettype none
`include "switch_settings.svh"

module hydra_switch
    import switch_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  port_vec_t wr_sop,
    input  port_vec_t wr_eop,
    input  port_vec_t wr_vld,
    input  data_t     wr_data [`SW_PORTS],
    output port_vec_t pause,
    output logic      full,
    output logic      almost_full,
    input  port_vec_t ready,
    output port_vec_t rd_sop,
    output port_vec_t rd_eop,
    output port_vec_t rd_vld,
    output data_t     rd_data [`SW_PORTS]
);

    localparam int TOTAL_SLOTS = `SW_PORTS * `SW_SLOTS;

    logic       mem_we [`SW_PORTS];
    slot_idx_t  mem_slot [`SW_PORTS];
    word_idx_t  mem_word [`SW_PORTS];
    data_t      mem_data [`SW_PORTS];
    logic       len_we [`SW_PORTS];
    len_t       len [`SW_PORTS];
    logic       has_free [`SW_PORTS];
    slot_idx_t  free_slot [`SW_PORTS];
    slot_cnt_t  free_cnt [`SW_PORTS];
    port_vec_t  join_req;
    port_vec_t  join_gnt;
    port_id_t   join_dest [`SW_PORTS];
    prior_t     join_prior [`SW_PORTS];
    slot_addr_t join_addr [`SW_PORTS];
    port_vec_t  enq;
    prior_t     enq_prior;
    slot_addr_t enq_addr;
    port_vec_t  pop;
    port_vec_t  has_pkt;
    slot_addr_t head_addr [`SW_PORTS];
    port_vec_t  bank_req [`SW_PORTS];               // per out port, one bit per bank.
    port_vec_t  bank_rd_req [`SW_PORTS];            // per bank, one bit per out port.
    port_vec_t  rd_gnt [`SW_PORTS];
    port_vec_t  gnt;
    slot_idx_t  rd_slot [`SW_PORTS];
    logic       bank_vld [`SW_PORTS];
    data_t      bank_data [`SW_PORTS];
    logic       bank_last [`SW_PORTS];
    logic [$clog2(TOTAL_SLOTS+1)-1:0] free_total;

    // turn out port requests around to the banks, and grants back.
    always_comb begin
        gnt = '0;
        for (int b = 0; b < `SW_PORTS; b++) begin
            for (int o = 0; o < `SW_PORTS; o++) begin
                bank_rd_req[b][o] = bank_req[o][b];
                gnt[o] = gnt[o] | rd_gnt[b][o];
            end
        end
    end

    for (genvar p = 0; p < `SW_PORTS; p++) begin : g_port
        port_wr_frontend #(.BANK(port_id_t'(p))) u_wr (
            .clk(clk), .rst_n(rst_n),
            .wr_sop(wr_sop[p]), .wr_eop(wr_eop[p]), .wr_vld(wr_vld[p]),
            .wr_data(wr_data[p]), .has_free(has_free[p]), .free_slot(free_slot[p]),
            .join_gnt(join_gnt[p]), .pause(pause[p]),
            .mem_we(mem_we[p]), .mem_slot(mem_slot[p]), .mem_word(mem_word[p]),
            .mem_data(mem_data[p]), .len_we(len_we[p]), .len(len[p]),
            .join_req(join_req[p]), .join_dest(join_dest[p]),
            .join_prior(join_prior[p]), .join_addr(join_addr[p])
        );

        sram_bank u_bank (
            .clk(clk), .rst_n(rst_n),
            .mem_we(mem_we[p]), .mem_slot(mem_slot[p]), .mem_word(mem_word[p]),
            .mem_data(mem_data[p]), .len_we(len_we[p]), .len(len[p]),
            .rd_req(bank_rd_req[p]), .rd_slot_in(rd_slot),
            .has_free(has_free[p]), .free_slot(free_slot[p]), .free_cnt(free_cnt[p]),
            .rd_gnt(rd_gnt[p]), .bank_vld(bank_vld[p]),
            .bank_data(bank_data[p]), .bank_last(bank_last[p])
        );

        port_queue_mgr u_queue (
            .clk(clk), .rst_n(rst_n),
            .enq(enq[p]), .enq_prior(enq_prior), .enq_addr(enq_addr),
            .pop(pop[p]), .head_addr(head_addr[p]), .has_pkt(has_pkt[p])
        );

        port_rd_frontend u_rd (
            .clk(clk), .rst_n(rst_n),
            .ready(ready[p]), .has_pkt(has_pkt[p]), .head_addr(head_addr[p]),
            .gnt(gnt[p]), .bank_vld(bank_vld), .bank_data(bank_data),
            .bank_last(bank_last), .pop(pop[p]), .bank_req(bank_req[p]),
            .rd_slot(rd_slot[p]), .rd_sop(rd_sop[p]), .rd_eop(rd_eop[p]),
            .rd_vld(rd_vld[p]), .rd_data(rd_data[p])
        );
    end

    join_arbiter u_join (
        .clk(clk), .rst_n(rst_n),
        .join_req(join_req), .join_dest(join_dest), .join_prior(join_prior),
        .join_addr(join_addr), .join_gnt(join_gnt),
        .enq(enq), .enq_prior(enq_prior), .enq_addr(enq_addr)
    );

    always_comb begin
        free_total = '0;
        for (int b = 0; b < `SW_PORTS; b++) begin
            free_total = free_total + free_cnt[b];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full        <= 1'b0;
            almost_full <= 1'b0;
        end else begin
            full        <= (free_total == '0);
            almost_full <= (free_total < TOTAL_SLOTS / 2);    // under half free.
        end
    end

endmodule

`default_nettype wire

// File: tests/tb_hydra_switch.sv
`timescale 1ns/10ps
`default_nettype none
`include "switch_settings.svh"

module tb_hydra_switch
    import switch_pkg::*;
();

    localparam int MAX_PKT     = 64;
    localparam int MAX_EXP     = 64;
    localparam int MAX_EVT     = 32;
    localparam int SRC_LSB     = 8;                 // source input tag in the header.
    localparam int PAUSE_LIMIT = 2000;
    localparam int CYCLE_LIMIT = 5000;
    localparam int DRAIN_LIMIT = 2000;

    logic      clk;
    logic      rst_n;
    port_vec_t wr_sop;
    port_vec_t wr_eop;
    port_vec_t wr_vld;
    data_t     wr_data [`SW_PORTS];
    port_vec_t ready;
    port_vec_t pause;
    logic      full;
    logic      almost_full;
    port_vec_t rd_sop;
    port_vec_t rd_eop;
    port_vec_t rd_vld;
    data_t     rd_data [`SW_PORTS];

    // tables loaded from the golden file.
    int        n_pkt = 0;
    int        pkt_port [MAX_PKT];
    int        pkt_cycle [MAX_PKT];
    int        pkt_gap_lo [MAX_PKT];
    int        pkt_gap_hi [MAX_PKT];
    int        pkt_len [MAX_PKT];
    data_t     pkt_words [MAX_PKT][`SW_WORDS];
    int        n_exp = 0;
    int        exp_port [MAX_EXP];
    int        exp_len [MAX_EXP];
    data_t     exp_words [MAX_EXP][`SW_WORDS];
    logic      exp_done [MAX_EXP];
    int        n_rdy = 0;
    int        rdy_port [MAX_EVT];
    logic      rdy_val [MAX_EVT];
    int        rdy_cycle [MAX_EVT];
    int        n_st = 0;
    int        st_cycle [MAX_EVT];
    port_vec_t st_pause [MAX_EVT];
    logic      st_full [MAX_EVT];
    logic      st_af [MAX_EVT];

    data_t       got_words [`SW_PORTS][`SW_WORDS];
    int          cyc = 0;                           // clocks since reset release.
    int          chk_err = 0;
    int          misc_err = 0;

    hydra_switch uut (
        .clk(clk), .rst_n(rst_n),
        .wr_sop(wr_sop), .wr_eop(wr_eop), .wr_vld(wr_vld), .wr_data(wr_data),
        .pause(pause), .full(full), .almost_full(almost_full),
        .ready(ready), .rd_sop(rd_sop), .rd_eop(rd_eop), .rd_vld(rd_vld),
        .rd_data(rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) cyc <= cyc + 1;
    end

    task automatic check_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            chk_err++;
            $display("CHECK FAILED %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic load_golden();
        int              fd;
        int              bad;
        int              port;
        int              a;
        int              b;
        int              c;
        int              n;
        int              w;
        logic [7:0]      kind;
        logic [8*160-1:0] rest;
        bad = 0;
        fd = $fopen("tests/hydra_golden.txt", "r");
        if (fd == 0) begin
            misc_err++;
            $display("could not open tests/hydra_golden.txt");
            return;
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                void'($fgets(rest, fd));
            end else if (kind == "P") begin
                if ($fscanf(fd, "%d %d %d %d %d", port, a, b, c, n) != 5) bad++;
                pkt_port[n_pkt]   = port;
                pkt_cycle[n_pkt]  = a;
                pkt_gap_lo[n_pkt] = b;
                pkt_gap_hi[n_pkt] = c;
                pkt_len[n_pkt]    = n;
                for (int k = 0; k < n; k++) begin
                    if ($fscanf(fd, "%h", w) != 1) bad++;
                    pkt_words[n_pkt][k] = data_t'(w);
                end
                n_pkt++;
            end else if (kind == "R") begin
                if ($fscanf(fd, "%d %d %d", port, a, b) != 3) bad++;
                rdy_port[n_rdy]  = port;
                rdy_val[n_rdy]   = (a != 0);
                rdy_cycle[n_rdy] = b;
                n_rdy++;
            end else if (kind == "S") begin
                if ($fscanf(fd, "%d %h %d %d", a, b, c, n) != 4) bad++;
                st_cycle[n_st] = a;
                st_pause[n_st] = port_vec_t'(b);
                st_full[n_st]  = (c != 0);
                st_af[n_st]    = (n != 0);
                n_st++;
            end else if (kind == "E") begin
                if ($fscanf(fd, "%d %d", port, n) != 2) bad++;
                exp_port[n_exp] = port;
                exp_len[n_exp]  = n;
                exp_done[n_exp] = 1'b0;
                for (int k = 0; k < n; k++) begin
                    if ($fscanf(fd, "%h", w) != 1) bad++;
                    exp_words[n_exp][k] = data_t'(w);
                end
                n_exp++;
            end else begin
                misc_err++;
                $display("golden file holds a line of unknown kind");
            end
        end
        $fclose(fd);
        if (bad != 0) begin
            misc_err++;
            $display("golden file has %0d fields that could not be read", bad);
        end
    endtask

    task automatic wait_until_cycle(input int target);
        int guard;
        guard = 0;
        while (cyc < target && guard < CYCLE_LIMIT) begin
            @(negedge clk);
            guard++;
        end
        if (cyc < target) begin
            misc_err++;
            $display("timed out waiting for cycle %0d", target);
        end
    endtask

    // sends every packet of one input port, in file order.
    task automatic drive_input(input int p);
        int gap;
        int span;
        int waited;
        for (int i = 0; i < n_pkt; i++) begin
            if (pkt_port[i] != p) continue;
            wait_until_cycle(pkt_cycle[i]);
            span = pkt_gap_hi[i] - pkt_gap_lo[i] + 1;
            gap  = pkt_gap_lo[i] + int'($urandom % unsigned'(span));
            repeat (gap) @(negedge clk);
            waited = 0;
            while (pause[p] && waited < PAUSE_LIMIT) begin
                @(negedge clk);
                waited++;
            end
            if (pause[p]) begin
                misc_err++;
                $display("input %0d stayed paused too long, its packets stop here", p);
                return;
            end
            for (int k = 0; k < pkt_len[i]; k++) begin
                wr_vld[p]  = 1'b1;
                wr_sop[p]  = (k == 0);
                wr_eop[p]  = (k == pkt_len[i] - 1);
                wr_data[p] = pkt_words[i][k];
                @(negedge clk);
            end
            wr_vld[p] = 1'b0;
            wr_sop[p] = 1'b0;
            wr_eop[p] = 1'b0;
        end
    endtask

    task automatic check_status(input int i);
        check_value($sformatf("cycle %0d pause", cyc), int'(pause), int'(st_pause[i]));
        check_value($sformatf("cycle %0d full", cyc), int'(full), int'(st_full[i]));
        check_value($sformatf("cycle %0d almost_full", cyc), int'(almost_full), int'(st_af[i]));
    endtask

    // ready changes and status checks, by cycle.
    task automatic run_schedule();
        int last;
        last = 0;
        for (int i = 0; i < n_rdy; i++) if (rdy_cycle[i] > last) last = rdy_cycle[i];
        for (int i = 0; i < n_st; i++) if (st_cycle[i] > last) last = st_cycle[i];
        for (int c = 0; c <= last; c++) begin
            wait_until_cycle(c);
            for (int i = 0; i < n_rdy; i++) begin
                if (rdy_cycle[i] == c) ready[rdy_port[i]] = rdy_val[i];
            end
            for (int i = 0; i < n_st; i++) begin
                if (st_cycle[i] == c) check_status(i);
            end
        end
    endtask

    // oldest pending packet from the same source input must match.
    task automatic match_packet(input int o, input int n);
        int idx;
        int cnt;
        idx = -1;
        for (int i = n_exp - 1; i >= 0; i--) begin
            if (!exp_done[i] && exp_port[i] == o &&
                exp_words[i][0][SRC_LSB +: 2] == got_words[o][0][SRC_LSB +: 2]) idx = i;
        end
        if (idx < 0) begin
            misc_err++;
            $display("out %0d delivered header %h that no pending packet expects",
                     o, got_words[o][0]);
            return;
        end
        exp_done[idx] = 1'b1;
        check_value($sformatf("out %0d packet length", o), n, exp_len[idx]);
        cnt = (n < exp_len[idx]) ? n : exp_len[idx];
        for (int k = 0; k < cnt; k++) begin
            check_value($sformatf("out %0d rd_data word %0d", o, k),
                        int'(got_words[o][k]), int'(exp_words[idx][k]));
        end
    endtask

    task automatic watch_output(input int o);
        int   n;
        logic ended;
        forever begin
            @(negedge clk);
            if (!rd_vld[o]) begin
                check_value($sformatf("out %0d idle rd_sop", o), int'(rd_sop[o]), 0);
                check_value($sformatf("out %0d idle rd_eop", o), int'(rd_eop[o]), 0);
            end else begin
                check_value($sformatf("out %0d first word rd_sop", o), int'(rd_sop[o]), 1);
                got_words[o][0] = rd_data[o];
                n     = 1;
                ended = rd_eop[o];
                while (!ended && n <= `SW_WORDS) begin
                    @(negedge clk);
                    check_value($sformatf("out %0d mid-packet rd_vld", o), int'(rd_vld[o]), 1);
                    check_value($sformatf("out %0d mid-packet rd_sop", o), int'(rd_sop[o]), 0);
                    if (n < `SW_WORDS) got_words[o][n] = rd_data[o];
                    n++;
                    ended = rd_eop[o] || !rd_vld[o];
                end
                match_packet(o, n);
            end
        end
    endtask

    function automatic logic all_delivered();
        for (int i = 0; i < n_exp; i++) begin
            if (!exp_done[i]) return 1'b0;
        end
        return 1'b1;
    endfunction

    initial begin : main
        int guard;
        rst_n  = 1'b0;
        wr_sop = '0;
        wr_eop = '0;
        wr_vld = '0;
        ready  = '0;
        for (int p = 0; p < `SW_PORTS; p++) wr_data[p] = '0;
        void'($urandom(76125));
        load_golden();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        check_value("rd_vld after reset", int'(rd_vld), 0);
        check_value("rd_sop after reset", int'(rd_sop), 0);
        check_value("rd_eop after reset", int'(rd_eop), 0);
        check_value("pause after reset", int'(pause), 0);
        check_value("full after reset", int'(full), 0);
        check_value("almost_full after reset", int'(almost_full), 0);

        fork
            watch_output(0);
            watch_output(1);
            watch_output(2);
            watch_output(3);
        join_none
        fork
            drive_input(0);
            drive_input(1);
            drive_input(2);
            drive_input(3);
            run_schedule();
        join

        guard = 0;
        while (!all_delivered() && guard < DRAIN_LIMIT) begin
            @(negedge clk);
            guard++;
        end
        if (!all_delivered()) begin
            misc_err++;
            $display("timed out waiting for the expected packets to leave the switch");
        end

        $display("errors: %0d value mismatches, %0d other failures", chk_err, misc_err);
        if (chk_err == 0 && misc_err == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/hydra_golden.txt
# P in_port start_cycle gap_lo gap_hi n_words words : packet into an input port
# R out_port ready_value cycle | S cycle pause_mask full almost_full | E out_port n_words words
# header word: seq nibble, source input, priority, destination
# out 0 held back while input 0 queues priorities 3 1 2 0
R 1 1 0
R 2 1 0
R 3 1 0
R 0 1 80
P 0 0 1 3 3 1030 a001 a002
P 0 0 1 3 2 2010 a011
P 0 0 1 3 5 3020 a021 a022 a023 a024
P 0 0 1 3 1 4000
P 1 0 0 4 8 1101 b001 b002 b003 b004 b005 b006 b007
P 1 0 0 4 2 2122 b011
P 2 0 0 4 4 1213 c001 c002 c003
P 2 0 0 4 1 2201
P 3 0 0 4 3 1331 d001 d002
P 3 0 0 4 6 2302 d011 d012 d013 d014 d015
S 60 1 0 0
E 0 1 4000
E 0 2 2010 a011
E 0 5 3020 a021 a022 a023 a024
E 0 3 1030 a001 a002
E 1 8 1101 b001 b002 b003 b004 b005 b006 b007
E 1 1 2201
E 1 3 1331 d001 d002
E 2 2 2122 b011
E 2 6 2302 d011 d012 d013 d014 d015
E 3 4 1213 c001 c002 c003
# all inputs to out 2 at once
P 0 200 0 2 3 5012 e001 e002
P 0 200 0 2 4 6012 e011 e012 e013
P 1 200 0 2 2 3112 e101
P 1 200 0 2 5 4112 e111 e112 e113 e114
P 2 200 0 2 4 3212 e201 e202 e203
P 2 200 0 2 3 4212 e211 e212
P 3 200 0 2 3 3312 e301 e302
P 3 200 0 2 2 4312 e311
E 2 3 5012 e001 e002
E 2 4 6012 e011 e012 e013
E 2 2 3112 e101
E 2 5 4112 e111 e112 e113 e114
E 2 4 3212 e201 e202 e203
E 2 3 4212 e211 e212
E 2 3 3312 e301 e302
E 2 2 4312 e311
# fill the whole buffer with every ready low, then drain
R 0 0 390
R 1 0 390
R 2 0 390
R 3 0 390
P 0 400 0 3 3 7031 f001 f002
P 0 400 0 3 2 8021 f011
P 0 400 0 3 4 9011 f021 f022 f023
P 0 400 0 3 2 a001 f031
P 1 400 0 3 3 5103 f101 f102
P 1 400 0 3 2 6103 f111
P 1 400 0 3 4 7103 f121 f122 f123
P 1 400 0 3 3 8103 f131 f132
S 480 3 0 0
P 2 500 0 3 3 5210 f201 f202
S 560 3 0 1
P 2 600 0 3 2 6210 f211
P 2 600 0 3 4 7220 f221 f222 f223
P 2 600 0 3 2 8220 f231
P 3 600 0 3 2 5332 f301
P 3 600 0 3 3 6332 f311 f312
P 3 600 0 3 4 7332 f321 f322 f323
P 3 600 0 3 2 8332 f331
S 700 f 1 1
R 0 1 720
R 1 1 720
R 2 1 720
R 3 1 720
S 900 0 0 0
E 1 2 a001 f031
E 1 4 9011 f021 f022 f023
E 1 2 8021 f011
E 1 3 7031 f001 f002
E 3 3 5103 f101 f102
E 3 2 6103 f111
E 3 4 7103 f121 f122 f123
E 3 3 8103 f131 f132
E 0 3 5210 f201 f202
E 0 2 6210 f211
E 0 4 7220 f221 f222 f223
E 0 2 8220 f231
E 2 2 5332 f301
E 2 3 6332 f311 f312
E 2 4 7332 f321 f322 f323
E 2 2 8332 f331

// File: files.f
+incdir+include
src/switch_pkg.sv
src/port_wr_frontend.sv
src/sram_bank.sv
src/join_arbiter.sv
src/port_queue_mgr.sv
src/port_rd_frontend.sv
src/hydra_switch.sv
tests/tb_hydra_switch.sv

// File: run_sim.sh
#!/bin/sh
# build and run the switch testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module tb_hydra_switch -o sim_hydra
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_hydra > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Finished with no errors" sim.log; then
    exit 0
fi
exit 1
